// File: rv_exe_params.svh
`ifndef RV_EXE_PARAMS_SVH
`define RV_EXE_PARAMS_SVH

// Data and address width
`define RV_XLEN 32

// ADDI x0,x0,0
`define RV_NOP_INSTR 32'h0000_0013

// PC carried by bubbles
`define RV_RESET_PC 32'h0000_0000

`endif

// File: rv_exe_pkg.sv
`include "rv_exe_params.svh"

package rv_exe_pkg;

    typedef enum logic [3:0] {
        ALU_AND    = 4'b0000,
        ALU_OR     = 4'b0001,
        ALU_XOR    = 4'b0010,
        ALU_ADD    = 4'b0011,
        ALU_SUB    = 4'b0100,
        ALU_PASS_B = 4'b0110,
        ALU_SLL    = 4'b0111,
        ALU_SRL    = 4'b1000,
        ALU_SRA    = 4'b1010,
        ALU_SLTU   = 4'b1011,
        ALU_SLT    = 4'b1100
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_sel_e;

    // Branch condition expected to hold for the branch to be taken
    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_e;

    typedef enum logic {A_RS1, A_PC} a_src_e;
    typedef enum logic {B_RS2, B_IMM} b_src_e;

    typedef struct packed {
        alu_op_e  alu_op;
        imm_sel_e imm_sel;
        a_src_e   a_src;
        b_src_e   b_src;
        br_cond_e br_cond;
        logic     jump;
        logic     jalr;
        logic     link;
        logic     wr_en;
        logic     mem_req;
        logic     mem_store;
    } exe_ctrl_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         instr;
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
    } de_bundle_t;

    typedef struct packed {
        de_bundle_t de;
        exe_ctrl_t  ctrl;
    } ex_bundle_t;

    // Value holds the ALU result, the link address or the memory address
    typedef struct packed {
        logic                valid;
        logic                wr_en;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] value;
        logic                mem_req;
        logic                mem_store;
        logic [`RV_XLEN-1:0] store_data;
        logic                br_taken;
        logic [`RV_XLEN-1:0] br_target;
    } ex_result_t;

endpackage

// File: stage_reg.sv
`timescale 1ns/100ps

module stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  T     bubble,
    input  logic kill,
    input  T     d,
    output T     q
);

    // Kill replaces the incoming payload with a bubble
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= bubble;
        end else if (kill) begin
            q <= bubble;
        end else begin
            q <= d;
        end
    end

endmodule

// File: imm_gen.sv
`timescale 1ns/100ps
`include "rv_exe_params.svh"

module imm_gen (
    input  logic                 [31:0]         instr,
    input  rv_exe_pkg::imm_sel_e                sel,
    output logic                 [`RV_XLEN-1:0] imm
);
    import rv_exe_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (sel)
            IMM_I: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            IMM_S: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            // Branch offsets are in units of two bytes
            IMM_B: begin
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: exe_ctl.sv
`timescale 1ns/100ps
`include "rv_exe_params.svh"

module exe_ctl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   flush,
    input  rv_exe_pkg::de_bundle_t de_in,
    output rv_exe_pkg::ex_bundle_t ex_q
);
    import rv_exe_pkg::*;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // No write, no memory access, no branch; ALU yields zero
    localparam exe_ctrl_t CTRL_NOP = '{
        alu_op:    ALU_PASS_B,
        imm_sel:   IMM_NONE,
        a_src:     A_RS1,
        b_src:     B_IMM,
        br_cond:   BR_NONE,
        jump:      1'b0,
        jalr:      1'b0,
        link:      1'b0,
        wr_en:     1'b0,
        mem_req:   1'b0,
        mem_store: 1'b0
    };

    localparam ex_bundle_t BUBBLE = '{
        de: '{
            valid:    1'b0,
            pc:       `RV_RESET_PC,
            instr:    `RV_NOP_INSTR,
            rs1_data: '0,
            rs2_data: '0
        },
        ctrl: CTRL_NOP
    };

    // Shared by OP and OP-IMM, alt picks SUB or SRA
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic       writes_rd;
    exe_ctrl_t  ctrl;
    ex_bundle_t ex_d;
    logic       kill;

    assign opcode = de_in.instr[6:0];
    assign funct3 = de_in.instr[14:12];
    assign rd     = de_in.instr[11:7];

    always_comb begin
        ctrl      = CTRL_NOP;
        writes_rd = 1'b0;
        case (opcode)
            OPC_LUI: begin
                ctrl.imm_sel = IMM_U;
                writes_rd    = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.alu_op  = ALU_ADD;
                ctrl.imm_sel = IMM_U;
                ctrl.a_src   = A_PC;
                writes_rd    = 1'b1;
            end
            OPC_JAL: begin
                ctrl.alu_op  = ALU_ADD;
                ctrl.imm_sel = IMM_J;
                ctrl.a_src   = A_PC;
                ctrl.jump    = 1'b1;
                ctrl.link    = 1'b1;
                writes_rd    = 1'b1;
            end
            OPC_JALR: begin
                ctrl.alu_op  = ALU_ADD;
                ctrl.imm_sel = IMM_I;
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.link    = 1'b1;
                writes_rd    = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.alu_op  = ALU_ADD;
                ctrl.imm_sel = IMM_B;
                ctrl.a_src   = A_PC;
                case (funct3)
                    3'b000:  ctrl.br_cond = BR_EQ;
                    3'b001:  ctrl.br_cond = BR_NE;
                    3'b100:  ctrl.br_cond = BR_LT;
                    3'b101:  ctrl.br_cond = BR_GE;
                    3'b110:  ctrl.br_cond = BR_LTU;
                    3'b111:  ctrl.br_cond = BR_GEU;
                    default: ctrl.br_cond = BR_NONE;
                endcase
            end
            OPC_LOAD: begin
                ctrl.alu_op  = ALU_ADD;
                ctrl.imm_sel = IMM_I;
                ctrl.mem_req = 1'b1;
                writes_rd    = 1'b1;
            end
            OPC_STORE: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.imm_sel   = IMM_S;
                ctrl.mem_req   = 1'b1;
                ctrl.mem_store = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op  = alu_from_funct3(funct3, (funct3 == 3'b101) && de_in.instr[30]);
                ctrl.imm_sel = IMM_I;
                writes_rd    = 1'b1;
            end
            OPC_OP: begin
                ctrl.alu_op = alu_from_funct3(funct3, de_in.instr[30]);
                ctrl.b_src  = B_RS2;
                writes_rd   = 1'b1;
            end
            // FENCE, ECALL and EBREAK retire as no-ops
            OPC_FENCE, OPC_SYSTEM: ctrl = CTRL_NOP;
            default: ctrl = CTRL_NOP;
        endcase
        ctrl.wr_en = writes_rd && (rd != 5'd0);
    end

    assign ex_d = '{de: de_in, ctrl: ctrl};
    assign kill = stall || flush || !de_in.valid;

    stage_reg #(
        .T(ex_bundle_t)
    ) ex_reg_i (
        .clk    (clk),
        .rst    (rst),
        .bubble (BUBBLE),
        .kill   (kill),
        .d      (ex_d),
        .q      (ex_q)
    );

endmodule

// File: exe_datapath.sv
`timescale 1ns/100ps
`include "rv_exe_params.svh"

module exe_datapath (
    input  rv_exe_pkg::ex_bundle_t ex_q,
    output rv_exe_pkg::ex_result_t ex_next
);
    import rv_exe_pkg::*;

    de_bundle_t          de;
    exe_ctrl_t           ctrl;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_res;
    logic                rs_eq;
    logic                rs_lt;
    logic                rs_ltu;
    logic                cond_hold;
    logic [`RV_XLEN-1:0] target_base;
    logic [`RV_XLEN-1:0] target_sum;
    logic [`RV_XLEN-1:0] link_addr;

    assign de   = ex_q.de;
    assign ctrl = ex_q.ctrl;

    imm_gen imm_gen_i (
        .instr (de.instr),
        .sel   (ctrl.imm_sel),
        .imm   (imm)
    );

    assign op_a  = (ctrl.a_src == A_PC) ? de.pc : de.rs1_data;
    assign op_b  = (ctrl.b_src == B_IMM) ? imm : de.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // Branches always compare the two register operands
    assign rs_eq  = (de.rs1_data == de.rs2_data);
    assign rs_lt  = ($signed(de.rs1_data) < $signed(de.rs2_data));
    assign rs_ltu = (de.rs1_data < de.rs2_data);

    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   cond_hold = rs_eq;
            BR_NE:   cond_hold = !rs_eq;
            BR_LT:   cond_hold = rs_lt;
            BR_GE:   cond_hold = !rs_lt;
            BR_LTU:  cond_hold = rs_ltu;
            BR_GEU:  cond_hold = !rs_ltu;
            default: cond_hold = 1'b0;
        endcase
    end

    // JALR jumps relative to rs1, everything else relative to pc
    assign target_base = ctrl.jalr ? de.rs1_data : de.pc;
    assign target_sum  = target_base + imm;
    assign link_addr   = de.pc + `RV_XLEN'd4;

    always_comb begin
        ex_next.valid      = de.valid;
        ex_next.wr_en      = ctrl.wr_en;
        ex_next.rd         = de.instr[11:7];
        ex_next.value      = ctrl.link ? link_addr : alu_res;
        ex_next.mem_req    = ctrl.mem_req;
        ex_next.mem_store  = ctrl.mem_store;
        ex_next.store_data = de.rs2_data;
        ex_next.br_taken   = ctrl.jump || cond_hold;
        ex_next.br_target  = {target_sum[`RV_XLEN-1:1], target_sum[0] & !ctrl.jalr};
    end

endmodule

// File: rv_exe_top.sv
`timescale 1ns/100ps

module rv_exe_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   flush,
    input  rv_exe_pkg::de_bundle_t de_in,
    output rv_exe_pkg::ex_result_t ex_out
);
    import rv_exe_pkg::*;

    // Idle result, nothing valid and nothing requested
    localparam ex_result_t RESULT_IDLE = '0;

    ex_bundle_t ex_q;
    ex_result_t ex_next;

    exe_ctl exe_ctl_i (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (flush),
        .de_in (de_in),
        .ex_q  (ex_q)
    );

    exe_datapath exe_datapath_i (
        .ex_q    (ex_q),
        .ex_next (ex_next)
    );

    // Result register always accepts
    stage_reg #(
        .T(ex_result_t)
    ) result_reg_i (
        .clk    (clk),
        .rst    (rst),
        .bubble (RESULT_IDLE),
        .kill   (1'b0),
        .d      (ex_next),
        .q      (ex_out)
    );

endmodule

// File: tb_rv_exe.sv
`timescale 1ns/100ps
`include "rv_exe_params.svh"

module tb_rv_exe;
    import rv_exe_pkg::*;

    localparam int N_ALU    = 300;
    localparam int N_UPPER  = 60;
    localparam int N_BRANCH = 120;
    localparam int N_MEM    = 60;
    localparam int N_MISC   = 24;
    localparam int N_PIPE   = 200;
    localparam int N_TOTAL  = N_ALU + N_UPPER + N_BRANCH + N_MEM + N_MISC + N_PIPE + 10;

    // Expected result with the cycle count at which it shows on ex_out
    typedef struct packed {
        logic [31:0] due;
        logic [31:0] instr;
        ex_result_t  res;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        flush;
    de_bundle_t  de_in;
    ex_result_t  ex_out;
    int          cyc;
    int          errors;
    int          checks;
    logic [31:0] lcg_state;
    expect_t     exp_q[$];

    rv_exe_top rv_exe_top_i (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (flush),
        .de_in  (de_in),
        .ex_out (ex_out)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Sign boundary values three times in eight
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = next_random();
        case (r[31:29])
            3'd0:    return 32'h8000_0000;
            3'd1:    return 32'h7fff_ffff;
            3'd2:    return 32'hffff_ffff;
            default: return next_random();
        endcase
    endfunction

    // 0 OP, 1 OP-IMM, 2 LUI/AUIPC/JAL/JALR, 3 branch, 4 load/store, else misc
    function automatic logic [31:0] make_instr(input int cls);
        logic [31:0] i;
        logic [31:0] s;
        i = next_random();
        s = next_random();
        case (cls)
            0: begin
                i[6:0]   = 7'b0110011;
                i[31:25] = 7'b0;
                i[30]    = s[31] && (i[14:12] == 3'b000 || i[14:12] == 3'b101);
            end
            1: begin
                i[6:0] = 7'b0010011;
                if (i[14:12] == 3'b001 || i[14:12] == 3'b101) begin
                    i[31:25] = 7'b0;
                    i[30]    = s[31] && i[14];
                end
            end
            2: begin
                case (s[30:29])
                    2'd0: i[6:0] = 7'b0110111;
                    2'd1: i[6:0] = 7'b0010111;
                    2'd2: i[6:0] = 7'b1101111;
                    default: begin
                        i[6:0]   = 7'b1100111;
                        i[14:12] = 3'b000;
                    end
                endcase
            end
            3: begin
                i[6:0]   = 7'b1100011;
                i[14:12] = {s[31], s[31] & s[30], s[29]};
            end
            4: i[6:0] = s[31] ? 7'b0100011 : 7'b0000011;
            default: begin
                case (s[31:29])
                    3'd0:    i = 32'h0000_0073;
                    3'd1:    i = 32'h0010_0073;
                    3'd2:    i[6:0] = 7'b0001111;
                    3'd3:    i[6:0] = 7'b0000000;
                    3'd4:    i[6:0] = 7'b1011011;
                    3'd5:    i[6:0] = 7'b0101011;
                    default: i[6:0] = 7'b1111111;
                endcase
            end
        endcase
        if (s[27:25] == 3'd0) i[11:7] = 5'd0;
        return i;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) r = $signed(a) >>> b[4:0];
                else r = a >> b[4:0];
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic ex_result_t ref_result(input de_bundle_t d);
        ex_result_t  r;
        logic [31:0] i;
        logic [31:0] imm_i;
        logic        wr;
        i     = d.instr;
        imm_i = {{20{i[31]}}, i[31:20]};
        r     = '0;
        wr    = 1'b0;
        if (!d.valid) return r;
        r.valid = 1'b1;
        r.rd    = i[11:7];
        case (i[6:0])
            7'b0110111: begin
                wr      = 1'b1;
                r.value = {i[31:12], 12'b0};
            end
            7'b0010111: begin
                wr      = 1'b1;
                r.value = d.pc + {i[31:12], 12'b0};
            end
            7'b1101111, 7'b1100111: begin
                wr         = 1'b1;
                r.value    = d.pc + 32'd4;
                r.br_taken = 1'b1;
                if (i[6:0] == 7'b1101111) begin
                    r.br_target = d.pc + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
                end else begin
                    r.br_target = (d.rs1_data + imm_i) & ~32'd1;
                end
            end
            7'b1100011: begin
                case (i[14:12])
                    3'b000:  r.br_taken = d.rs1_data == d.rs2_data;
                    3'b001:  r.br_taken = d.rs1_data != d.rs2_data;
                    3'b100:  r.br_taken = $signed(d.rs1_data) < $signed(d.rs2_data);
                    3'b101:  r.br_taken = $signed(d.rs1_data) >= $signed(d.rs2_data);
                    3'b110:  r.br_taken = d.rs1_data < d.rs2_data;
                    default: r.br_taken = d.rs1_data >= d.rs2_data;
                endcase
                r.br_target = d.pc + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            end
            7'b0000011: begin
                wr        = 1'b1;
                r.mem_req = 1'b1;
                r.value   = d.rs1_data + imm_i;
            end
            7'b0100011: begin
                r.mem_req    = 1'b1;
                r.mem_store  = 1'b1;
                r.value      = d.rs1_data + {{20{i[31]}}, i[31:25], i[11:7]};
                r.store_data = d.rs2_data;
            end
            7'b0010011: begin
                wr      = 1'b1;
                r.value = alu_ref(i[14:12], i[30] && i[14:12] == 3'b101, d.rs1_data, imm_i);
            end
            7'b0110011: begin
                wr      = 1'b1;
                r.value = alu_ref(i[14:12], i[30], d.rs1_data, d.rs2_data);
            end
            default: wr = 1'b0;
        endcase
        r.wr_en = wr && (i[11:7] != 5'd0);
        return r;
    endfunction

    function automatic logic [4:0] flags(input ex_result_t r);
        return {r.valid, r.wr_en, r.mem_req, r.mem_store, r.br_taken};
    endfunction

    // Drive one cycle of input and queue what must come out two edges later
    task automatic send(input logic [31:0] instr, input logic [31:0] rs1, input logic [31:0] rs2,
                        input logic v, input logic st, input logic fl);
        de_bundle_t d;
        expect_t    e;
        d.valid    = v;
        d.pc       = next_random() & 32'hffff_fffc;
        d.instr    = instr;
        d.rs1_data = rs1;
        d.rs2_data = rs2;
        @(posedge clk);
        de_in   <= d;
        stall   <= st;
        flush   <= fl;
        d.valid  = v && !st && !fl;
        e.due    = cyc + 3;
        e.instr  = instr;
        e.res    = ref_result(d);
        exp_q.push_back(e);
    endtask

    task automatic compare(input expect_t e);
        ex_result_t x;
        x = e.res;
        checks++;
        if (flags(ex_out) !== flags(x)) begin
            errors++;
            $display("ERROR %0t: instr %h valid/wr/mreq/mst/br %b, expected %b",
                     $time, e.instr, flags(ex_out), flags(x));
        end
        if (x.wr_en && ex_out.rd !== x.rd) begin
            errors++;
            $display("ERROR %0t: instr %h rd %0d, expected %0d", $time, e.instr, ex_out.rd, x.rd);
        end
        if ((x.wr_en || x.mem_req) && ex_out.value !== x.value) begin
            errors++;
            $display("ERROR %0t: instr %h value %h, expected %h",
                     $time, e.instr, ex_out.value, x.value);
        end
        if (x.mem_store && ex_out.store_data !== x.store_data) begin
            errors++;
            $display("ERROR %0t: instr %h store data %h, expected %h",
                     $time, e.instr, ex_out.store_data, x.store_data);
        end
        // Branch targets are formed whether or not the branch is taken
        if ((x.br_taken || (x.valid && e.instr[6:0] == 7'b1100011)) &&
            ex_out.br_target !== x.br_target) begin
            errors++;
            $display("ERROR %0t: instr %h target %h, expected %h",
                     $time, e.instr, ex_out.br_target, x.br_target);
        end
    endtask

    always @(negedge clk) begin
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            compare(exp_q[0]);
            void'(exp_q.pop_front());
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        clk       = 1'b0;
        rst       = 1'b1;
        stall     = 1'b0;
        flush     = 1'b0;
        de_in     = '0;
        cyc       = 0;
        errors    = 0;
        checks    = 0;
        lcg_state = 32'h5b0e_6abb;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checks++;
        if ({ex_out.valid, ex_out.wr_en, ex_out.mem_req, ex_out.br_taken} !== 4'b0000) begin
            errors++;
            $display("ERROR %0t: result register not idle after reset", $time);
        end
        // Idle cycle ahead of the first instruction
        send(`RV_NOP_INSTR, '0, '0, 1'b0, 1'b0, 1'b0);
        repeat (N_ALU) begin
            send(make_instr(int'(next_random() >> 31)), pick_operand(), pick_operand(),
                 1'b1, 1'b0, 1'b0);
        end
        repeat (N_UPPER) send(make_instr(2), pick_operand(), pick_operand(), 1'b1, 1'b0, 1'b0);
        // Equal operands on about a quarter of the branches
        repeat (N_BRANCH) begin
            a = pick_operand();
            r = (next_random() < 32'h4000_0000) ? a : pick_operand();
            send(make_instr(3), a, r, 1'b1, 1'b0, 1'b0);
        end
        repeat (N_MEM) send(make_instr(4), pick_operand(), pick_operand(), 1'b1, 1'b0, 1'b0);
        repeat (N_MISC) send(make_instr(5), pick_operand(), pick_operand(), 1'b1, 1'b0, 1'b0);
        // Mixed stream with stall, flush and invalid cycles
        repeat (N_PIPE) begin
            r = next_random();
            send(make_instr(int'(r[21:6]) % 6), pick_operand(), pick_operand(),
                 r[31:29] != 3'd0, r[28:26] == 3'd0, r[25:23] == 3'd0);
        end
        send(`RV_NOP_INSTR, '0, '0, 1'b0, 1'b0, 1'b0);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #((N_TOTAL + 50) * 8 * 2);
        $display("Timeout: the run did not finish, %0d results still pending", exp_q.size());
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: files.f
+incdir+.
rv_exe_pkg.sv
stage_reg.sv
imm_gen.sv
exe_ctl.sv
exe_datapath.sv
rv_exe_top.sv
tb_rv_exe.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_rv_exe -f files.f -o tb_rv_exe \
    && ./obj_dir/tb_rv_exe > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
